//--- design/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath width of the core
`define XLEN 32

// exception or interrupt code, below the interrupt flag of xcause
`define CAUSE_W 31

// delegation register widths
`define MEDELEG_W 16
`define MIDELEG_W 12

// cycles a testbench wait loop may spin
`define TB_TIMEOUT_DEFAULT 1000

`endif

//--- design/csr_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

	typedef enum logic [1:0] {
		U = 2'b00,
		S = 2'b01,
		M = 2'b11
	} mode_t;

	typedef enum logic [11:0] {
		CSR_USTATUS  = 12'h000,
		CSR_UIE      = 12'h004,
		CSR_UTVEC    = 12'h005,
		CSR_USCRATCH = 12'h040,
		CSR_UEPC     = 12'h041,
		CSR_UCAUSE   = 12'h042,
		CSR_UTVAL    = 12'h043,
		CSR_UIP      = 12'h044,
		CSR_SSTATUS  = 12'h100,
		CSR_SEDELEG  = 12'h102,
		CSR_SIDELEG  = 12'h103,
		CSR_SIE      = 12'h104,
		CSR_STVEC    = 12'h105,
		CSR_SSCRATCH = 12'h140,
		CSR_SEPC     = 12'h141,
		CSR_SCAUSE   = 12'h142,
		CSR_STVAL    = 12'h143,
		CSR_SIP      = 12'h144,
		CSR_STIMECMP = 12'h14d,
		CSR_MSTATUS  = 12'h300,
		CSR_MISA     = 12'h301,
		CSR_MEDELEG  = 12'h302,
		CSR_MIDELEG  = 12'h303,
		CSR_MIE      = 12'h304,
		CSR_MTVEC    = 12'h305,
		CSR_MSCRATCH = 12'h340,
		CSR_MEPC     = 12'h341,
		CSR_MCAUSE   = 12'h342,
		CSR_MTVAL    = 12'h343,
		CSR_MIP      = 12'h344,
		CSR_MTIMECMP = 12'h7c0,
		CSR_UTIMECMP = 12'h7c2, // custom slot, no standard address
		CSR_CYCLE    = 12'hc00,
		CSR_TIME     = 12'hc01,
		CSR_CYCLEH   = 12'hc80,
		CSR_TIMEH    = 12'hc81
	} csr_addr_t;

	// funct3 low bits of csrrw/csrrs/csrrc
	typedef enum logic [1:0] {
		CSR_RW = 2'b01,
		CSR_RS = 2'b10,
		CSR_RC = 2'b11
	} csr_op_t;

	typedef enum logic [`CAUSE_W-1:0] {
		I_ADDR_MISALIGNED = 0,
		I_ILLEGAL         = 2,
		BREAKPOINT        = 3,
		ECALL_U           = 8,
		ECALL_S           = 9,
		ECALL_M           = 11
	} exc_code_t;

	typedef struct packed {
		logic            valid;
		csr_op_t         op;
		csr_addr_t       addr;
		logic [`XLEN-1:0] src;
	} csr_req_t;

	typedef struct packed {
		logic             pending;
		logic [`XLEN-1:0] cause; // msb set for interrupts
		logic [`XLEN-1:0] pc;
	} trap_req_t;

	typedef struct packed {
		logic m_ret;
		logic s_ret;
		logic u_ret;
	} xret_t;

	typedef struct packed {
		logic m_eie;
		logic m_tie;
		logic s_eie;
		logic s_tie;
		logic u_eie;
		logic u_tie;
		logic u_sie;
	} irq_en_t;

	typedef struct packed {
		logic m_timer;
		logic s_timer;
		logic u_timer;
	} timer_irq_t;

endpackage

`default_nettype wire

//--- design/csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_unit (
	input  logic               clk,
	input  logic               nrst,
	input  csr_pkg::csr_req_t  csr_req,
	input  logic [`XLEN-1:0]   csr_data,
	output logic               csr_we,
	output csr_pkg::csr_addr_t csr_wb_addr,
	output logic [`XLEN-1:0]   csr_wb,
	output logic [`XLEN-1:0]   rd_data
);
	import csr_pkg::*;

	logic src_zero;

	assign src_zero = (csr_req.src == '0);

	// read-modify-write on the current register value
	always_comb
	begin
		csr_wb = csr_data;
		csr_we = 1'b0;
		case (csr_req.op)
			CSR_RW:
			begin
				csr_wb = csr_req.src;
				csr_we = csr_req.valid;
			end
			CSR_RS:
			begin
				csr_wb = csr_data | csr_req.src;
				csr_we = csr_req.valid & ~src_zero; // csrrs x0 only reads
			end
			CSR_RC:
			begin
				csr_wb = csr_data & ~csr_req.src;
				csr_we = csr_req.valid & ~src_zero;
			end
			default: ;
		endcase
	end

	assign csr_wb_addr = csr_req.addr;
	assign rd_data     = csr_data; // old value back to the pipeline

	a_we_valid: assert property (@(posedge clk) disable iff (!nrst)
		csr_we |-> csr_req.valid);

endmodule

`default_nettype wire

//--- design/csr_timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_timer (
	input  logic                clk,
	input  logic                nrst,
	input  logic                csr_we,
	input  csr_pkg::csr_addr_t  csr_wb_addr,
	input  logic [`XLEN-1:0]    csr_wb,
	output csr_pkg::timer_irq_t timers,
	output logic [63:0]         time_data,
	output logic [`XLEN-1:0]    mtimecmp,
	output logic [`XLEN-1:0]    stimecmp,
	output logic [`XLEN-1:0]    utimecmp
);
	import csr_pkg::*;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			time_data <= '0;
			mtimecmp <= '0;
			stimecmp <= '0;
			utimecmp <= '0;
			timers <= '0;
		end
		else
		begin
			time_data <= time_data + 64'd1; // free running
			if (csr_we && csr_wb_addr == CSR_MTIMECMP)
				mtimecmp <= csr_wb;
			if (csr_we && csr_wb_addr == CSR_STIMECMP)
				stimecmp <= csr_wb;
			if (csr_we && csr_wb_addr == CSR_UTIMECMP)
				utimecmp <= csr_wb;
			// compare against zero-extended values
			timers.m_timer <= (time_data >= {32'b0, mtimecmp});
			timers.s_timer <= (time_data >= {32'b0, stimecmp});
			timers.u_timer <= (time_data >= {32'b0, utimecmp});
		end
	end

endmodule

`default_nettype wire

//--- design/csr_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_regfile (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   csr_we,
	input  csr_pkg::csr_addr_t     csr_wb_addr,
	input  logic [`XLEN-1:0]       csr_wb,
	input  csr_pkg::csr_addr_t     csr_addr_r,
	input  csr_pkg::trap_req_t     trap,
	input  csr_pkg::xret_t         xret,
	input  logic                   m_interrupt,
	input  logic                   s_interrupt,
	input  logic                   u_interrupt,
	input  csr_pkg::timer_irq_t    timers,
	input  logic [63:0]            time_data,
	input  logic [`XLEN-1:0]       mtimecmp,
	input  logic [`XLEN-1:0]       stimecmp,
	input  logic [`XLEN-1:0]       utimecmp,
	output logic [`XLEN-1:0]       csr_data,
	output logic [`XLEN-1:0]       epc,
	output csr_pkg::mode_t         current_mode,
	output csr_pkg::irq_en_t       irq_en
);
	import csr_pkg::*;

	mode_t next_mode;

	logic status_sie, status_mie, status_uie;
	logic status_spie, status_mpie, status_upie;
	logic status_spp;
	mode_t status_mpp;
	logic status_sum;
	logic meie, seie, ueie;
	logic mtie, stie, utie;
	logic usie, usip;

	logic [`XLEN-1:2] mtvec, stvec, utvec;
	logic [`XLEN-1:2] mepc, sepc, uepc;
	logic [`XLEN-1:0] mscratch, sscratch, uscratch;
	logic [`XLEN-1:0] mcause, scause, ucause;
	logic [`XLEN-1:0] mtval, stval, utval;
	logic [`MEDELEG_W-1:0] medeleg, sedeleg;
	logic [`MIDELEG_W-1:0] mideleg, sideleg;

	logic [`XLEN-1:0] mstatus, sstatus, ustatus;
	logic [`XLEN-1:0] mie, sie, uie, mip, sip, uip;

	logic                 cause_irq;
	logic [`CAUSE_W-1:0]  cause_code;
	logic [`MEDELEG_W-1:0] mideleg_x, sideleg_x; // widened to exception width
	logic                 deleg_m, deleg_s;
	logic [`XLEN-1:0]     tval;

	assign mstatus = {13'b0, status_sum, 5'b0, status_mpp, 2'b0, status_spp, status_mpie,
		1'b0, status_spie, status_upie, status_mie, 1'b0, status_sie, status_uie};
	assign sstatus = {13'b0, status_sum, 9'b0, status_spp, 2'b0, status_spie, status_upie,
		2'b0, status_sie, status_uie};
	assign ustatus = {27'b0, status_upie, 3'b0, status_uie};

	assign mip = {20'b0, m_interrupt, 1'b0, s_interrupt, 1'b0, timers.m_timer, 1'b0,
		timers.s_timer, 5'b0};
	assign mie = {20'b0, meie, 1'b0, seie, 1'b0, mtie, 1'b0, stie, 5'b0};
	assign sip = {22'b0, s_interrupt, 3'b0, timers.s_timer, 5'b0};
	assign sie = {22'b0, seie, 3'b0, stie, 5'b0};
	assign uip = {23'b0, u_interrupt, 3'b0, timers.u_timer, 3'b0, usip};
	assign uie = {23'b0, ueie, 3'b0, utie, 3'b0, usie};

	always_comb
	begin
		case (csr_addr_r)
			CSR_MISA:     csr_data = {2'b01, 4'b0, 26'b00000101000011000100000001};
			CSR_MSTATUS:  csr_data = mstatus;
			CSR_MIE:      csr_data = mie;
			CSR_MIP:      csr_data = mip;
			CSR_MTVEC:    csr_data = {mtvec, 2'b0}; // direct mode only
			CSR_MSCRATCH: csr_data = mscratch;
			CSR_MEPC:     csr_data = {mepc, 2'b0};
			CSR_MCAUSE:   csr_data = mcause;
			CSR_MTVAL:    csr_data = mtval;
			CSR_MEDELEG:  csr_data = {{(`XLEN-`MEDELEG_W){1'b0}}, medeleg};
			CSR_MIDELEG:  csr_data = {{(`XLEN-`MIDELEG_W){1'b0}}, mideleg};
			CSR_MTIMECMP: csr_data = mtimecmp;
			CSR_SSTATUS:  csr_data = sstatus;
			CSR_SIE:      csr_data = sie;
			CSR_SIP:      csr_data = sip;
			CSR_STVEC:    csr_data = {stvec, 2'b0};
			CSR_SSCRATCH: csr_data = sscratch;
			CSR_SEPC:     csr_data = {sepc, 2'b0};
			CSR_SCAUSE:   csr_data = scause;
			CSR_STVAL:    csr_data = stval;
			CSR_SEDELEG:  csr_data = {{(`XLEN-`MEDELEG_W){1'b0}}, sedeleg};
			CSR_SIDELEG:  csr_data = {{(`XLEN-`MIDELEG_W){1'b0}}, sideleg};
			CSR_STIMECMP: csr_data = stimecmp;
			CSR_USTATUS:  csr_data = ustatus;
			CSR_UIE:      csr_data = uie;
			CSR_UIP:      csr_data = uip;
			CSR_UTVEC:    csr_data = {utvec, 2'b0};
			CSR_USCRATCH: csr_data = uscratch;
			CSR_UEPC:     csr_data = {uepc, 2'b0};
			CSR_UCAUSE:   csr_data = ucause;
			CSR_UTVAL:    csr_data = utval;
			CSR_UTIMECMP: csr_data = utimecmp;
			CSR_TIME, CSR_CYCLE:   csr_data = time_data[31:0];
			CSR_TIMEH, CSR_CYCLEH: csr_data = time_data[63:32];
			default:      csr_data = '0;
		endcase
	end

	assign cause_irq  = trap.cause[`XLEN-1];
	assign cause_code = trap.cause[`CAUSE_W-1:0];
	assign mideleg_x  = {{(`MEDELEG_W-`MIDELEG_W){1'b0}}, mideleg};
	assign sideleg_x  = {{(`MEDELEG_W-`MIDELEG_W){1'b0}}, sideleg};
	// codes beyond the delegation width are never delegated
	assign deleg_m = (cause_code < `MEDELEG_W) &&
		(cause_irq ? mideleg_x[cause_code[3:0]] : medeleg[cause_code[3:0]]);
	assign deleg_s = (cause_code < `MEDELEG_W) &&
		(cause_irq ? sideleg_x[cause_code[3:0]] : sedeleg[cause_code[3:0]]);
	assign tval = (!cause_irq && cause_code == I_ADDR_MISALIGNED) ? trap.pc : '0;

	always_comb
	begin
		next_mode = current_mode;
		if (trap.pending)
		begin
			case (current_mode)
				S:       next_mode = deleg_m ? S : M;
				U:       next_mode = deleg_s ? U : S;
				default: next_mode = M;
			endcase
		end
		else if (xret.m_ret)
			next_mode = status_mpp;
		else if (xret.s_ret)
			next_mode = status_spp ? S : U;
		else if (xret.u_ret)
			next_mode = U;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= M; // hart comes out of reset in M
			status_sie <= 1'b0;
			status_mie <= 1'b0;
			status_uie <= 1'b0;
			status_spie <= 1'b0;
			status_mpie <= 1'b0;
			status_upie <= 1'b0;
			status_spp <= 1'b0;
			status_mpp <= M;
			status_sum <= 1'b0;
			meie <= 1'b0;
			seie <= 1'b0;
			ueie <= 1'b0;
			mtie <= 1'b0;
			stie <= 1'b0;
			utie <= 1'b0;
			usie <= 1'b0;
			usip <= 1'b0;
			mtvec <= '0;
			stvec <= '0;
			utvec <= '0;
			mepc <= '0;
			sepc <= '0;
			uepc <= '0;
			mscratch <= '0;
			sscratch <= '0;
			uscratch <= '0;
			mcause <= '0;
			scause <= '0;
			ucause <= '0;
			mtval <= '0;
			stval <= '0;
			utval <= '0;
			medeleg <= '0;
			mideleg <= '0;
			sedeleg <= '0;
			sideleg <= '0;
		end
		else
		begin
			current_mode <= next_mode;
			if (trap.pending)
			begin
				case (next_mode)
					M:
					begin
						mepc <= trap.pc[`XLEN-1:2];
						mcause <= trap.cause;
						mtval <= tval;
						status_mpie <= status_mie;
						status_mie <= 1'b0;
						status_mpp <= current_mode;
					end
					S:
					begin
						sepc <= trap.pc[`XLEN-1:2];
						scause <= trap.cause;
						stval <= tval;
						status_spie <= status_sie;
						status_sie <= 1'b0;
						status_spp <= current_mode[0]; // 1 only when coming from S
					end
					default:
					begin
						uepc <= trap.pc[`XLEN-1:2];
						ucause <= trap.cause;
						utval <= tval;
						status_upie <= status_uie;
						status_uie <= 1'b0;
					end
				endcase
			end
			else if (xret.m_ret)
			begin
				status_mie <= status_mpie;
				status_mpie <= 1'b1;
				status_mpp <= U;
			end
			else if (xret.s_ret)
			begin
				status_sie <= status_spie;
				status_spie <= 1'b1;
				status_spp <= 1'b0;
			end
			else if (xret.u_ret)
			begin
				status_uie <= status_upie;
				status_upie <= 1'b1;
			end
			else if (csr_we)
			begin
				case (csr_wb_addr)
					CSR_MSTATUS:
					begin
						status_uie <= csr_wb[0];
						status_sie <= csr_wb[1];
						status_mie <= csr_wb[3];
						status_upie <= csr_wb[4];
						status_spie <= csr_wb[5];
						status_mpie <= csr_wb[7];
						status_spp <= csr_wb[8];
						// reserved encoding 2 falls back to U
						status_mpp <= (csr_wb[12:11] == 2'b10) ? U : mode_t'(csr_wb[12:11]);
						status_sum <= csr_wb[18];
					end
					CSR_SSTATUS:
					begin
						status_uie <= csr_wb[0];
						status_sie <= csr_wb[1];
						status_upie <= csr_wb[4];
						status_spie <= csr_wb[5];
						status_spp <= csr_wb[8];
						status_sum <= csr_wb[18];
					end
					CSR_USTATUS:
					begin
						status_uie <= csr_wb[0];
						status_upie <= csr_wb[4];
					end
					CSR_MIE:
					begin
						stie <= csr_wb[5];
						mtie <= csr_wb[7];
						seie <= csr_wb[9];
						meie <= csr_wb[11];
					end
					CSR_SIE:
					begin
						stie <= csr_wb[5];
						seie <= csr_wb[9];
					end
					CSR_UIE:
					begin
						usie <= csr_wb[0];
						utie <= csr_wb[4];
						ueie <= csr_wb[8];
					end
					CSR_UIP:      usip <= csr_wb[0]; // only the software bit is writable
					CSR_MTVEC:    mtvec <= csr_wb[`XLEN-1:2];
					CSR_STVEC:    stvec <= csr_wb[`XLEN-1:2];
					CSR_UTVEC:    utvec <= csr_wb[`XLEN-1:2];
					CSR_MEPC:     mepc <= csr_wb[`XLEN-1:2];
					CSR_SEPC:     sepc <= csr_wb[`XLEN-1:2];
					CSR_UEPC:     uepc <= csr_wb[`XLEN-1:2];
					CSR_MSCRATCH: mscratch <= csr_wb;
					CSR_SSCRATCH: sscratch <= csr_wb;
					CSR_USCRATCH: uscratch <= csr_wb;
					CSR_MCAUSE:   mcause <= csr_wb;
					CSR_SCAUSE:   scause <= csr_wb;
					CSR_UCAUSE:   ucause <= csr_wb;
					CSR_MTVAL:    mtval <= csr_wb;
					CSR_STVAL:    stval <= csr_wb;
					CSR_UTVAL:    utval <= csr_wb;
					CSR_MEDELEG:  medeleg <= csr_wb[`MEDELEG_W-1:0];
					CSR_MIDELEG:  mideleg <= csr_wb[`MIDELEG_W-1:0];
					CSR_SEDELEG:  sedeleg <= csr_wb[`MEDELEG_W-1:0];
					CSR_SIDELEG:  sideleg <= csr_wb[`MIDELEG_W-1:0];
					default:      ;
				endcase
			end
		end
	end

	// return target, else the vector of the mode being entered
	always_comb
	begin
		if (xret.m_ret)
			epc = {mepc, 2'b0};
		else if (xret.s_ret)
			epc = {sepc, 2'b0};
		else if (xret.u_ret)
			epc = {uepc, 2'b0};
		else
		begin
			case (next_mode)
				M:       epc = {mtvec, 2'b0};
				S:       epc = {stvec, 2'b0};
				default: epc = {utvec, 2'b0};
			endcase
		end
	end

	assign irq_en.m_eie = meie & status_mie;
	assign irq_en.m_tie = mtie & status_mie;
	assign irq_en.s_eie = seie & status_sie;
	assign irq_en.s_tie = stie & status_sie;
	assign irq_en.u_eie = ueie & status_uie;
	assign irq_en.u_tie = utie & status_uie;
	assign irq_en.u_sie = usie & status_uie;

	a_one_ret: assert property (@(posedge clk) disable iff (!nrst)
		$onehot0({xret.m_ret, xret.s_ret, xret.u_ret}));
	a_mode_legal: assert property (@(posedge clk) disable iff (!nrst)
		current_mode != 2'b10);

endmodule

`default_nettype wire

//--- design/csr_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_top (
	input  logic                clk,
	input  logic                nrst,
	input  csr_pkg::csr_req_t   csr_req,
	input  csr_pkg::trap_req_t  trap,
	input  csr_pkg::xret_t      xret,
	input  logic                m_interrupt,
	input  logic                s_interrupt,
	input  logic                u_interrupt,
	output logic [`XLEN-1:0]    rd_data,
	output logic [`XLEN-1:0]    epc,
	output csr_pkg::mode_t      current_mode,
	output csr_pkg::irq_en_t    irq_en,
	output csr_pkg::timer_irq_t timers
);
	import csr_pkg::*;

	logic             csr_we;
	csr_addr_t        csr_wb_addr;
	logic [`XLEN-1:0] csr_wb;
	logic [`XLEN-1:0] csr_data;
	logic [63:0]      time_data;
	logic [`XLEN-1:0] mtimecmp, stimecmp, utimecmp;

	csr_unit unit0 (
		.clk         (clk),
		.nrst        (nrst),
		.csr_req     (csr_req),
		.csr_data    (csr_data),
		.csr_we      (csr_we),
		.csr_wb_addr (csr_wb_addr),
		.csr_wb      (csr_wb),
		.rd_data     (rd_data)
	);

	// read port follows the request address
	csr_regfile regfile0 (
		.clk          (clk),
		.nrst         (nrst),
		.csr_we       (csr_we),
		.csr_wb_addr  (csr_wb_addr),
		.csr_wb       (csr_wb),
		.csr_addr_r   (csr_req.addr),
		.trap         (trap),
		.xret         (xret),
		.m_interrupt  (m_interrupt),
		.s_interrupt  (s_interrupt),
		.u_interrupt  (u_interrupt),
		.timers       (timers),
		.time_data    (time_data),
		.mtimecmp     (mtimecmp),
		.stimecmp     (stimecmp),
		.utimecmp     (utimecmp),
		.csr_data     (csr_data),
		.epc          (epc),
		.current_mode (current_mode),
		.irq_en       (irq_en)
	);

	csr_timer timer0 (
		.clk         (clk),
		.nrst        (nrst),
		.csr_we      (csr_we),
		.csr_wb_addr (csr_wb_addr),
		.csr_wb      (csr_wb),
		.timers      (timers),
		.time_data   (time_data),
		.mtimecmp    (mtimecmp),
		.stimecmp    (stimecmp),
		.utimecmp    (utimecmp)
	);

endmodule

`default_nettype wire

//--- bench/csr_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_tb;
	import csr_pkg::*;

	logic clk;
	logic nrst;
	csr_req_t csr_req;
	trap_req_t trap;
	xret_t xret;
	logic m_interrupt, s_interrupt, u_interrupt;
	logic [`XLEN-1:0] rd_data;
	logic [`XLEN-1:0] epc;
	mode_t current_mode;
	irq_en_t irq_en;
	timer_irq_t timers;

	csr_top dut0 (
		.clk          (clk),
		.nrst         (nrst),
		.csr_req      (csr_req),
		.trap         (trap),
		.xret         (xret),
		.m_interrupt  (m_interrupt),
		.s_interrupt  (s_interrupt),
		.u_interrupt  (u_interrupt),
		.rd_data      (rd_data),
		.epc          (epc),
		.current_mode (current_mode),
		.irq_en       (irq_en),
		.timers       (timers)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: actual 0x%0h expected 0x%0h", name, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("RESULT: FAIL");
		$fatal(1, "a wait loop ran out of cycles");
	endtask

	// idle request, address kept so rd_data stays useful
	task automatic park_req(input csr_addr_t addr);
		csr_req <= '{valid: 1'b0, op: CSR_RS, addr: addr, src: '0};
	endtask

	// one request cycle, old value sampled mid-cycle
	task automatic access_reg(input csr_op_t op, input csr_addr_t addr,
		input logic [31:0] src, output logic [31:0] old);
		@(posedge clk);
		csr_req <= '{valid: 1'b1, op: op, addr: addr, src: src};
		@(negedge clk);
		old = rd_data;
		@(posedge clk);
		park_req(addr); // write commits at this edge
	endtask

	task automatic csr_rw(input csr_addr_t addr, input logic [31:0] src,
		output logic [31:0] old);
		access_reg(CSR_RW, addr, src, old);
	endtask

	task automatic csr_set(input csr_addr_t addr, input logic [31:0] src,
		output logic [31:0] old);
		access_reg(CSR_RS, addr, src, old);
	endtask

	task automatic csr_clr(input csr_addr_t addr, input logic [31:0] src,
		output logic [31:0] old);
		access_reg(CSR_RC, addr, src, old);
	endtask

	task automatic read_csr(input csr_addr_t addr, output logic [31:0] val);
		csr_set(addr, 32'h0, val); // zero source means no write
	endtask

	task automatic do_trap(input logic [31:0] cause, input logic [31:0] pc,
		output logic [31:0] epc_seen);
		@(posedge clk);
		trap <= '{pending: 1'b1, cause: cause, pc: pc};
		@(negedge clk);
		epc_seen = epc;
		@(posedge clk);
		trap <= '{pending: 1'b0, cause: '0, pc: '0};
	endtask

	task automatic do_ret(input xret_t r, output logic [31:0] epc_seen);
		@(posedge clk);
		xret <= r;
		@(negedge clk);
		epc_seen = epc;
		@(posedge clk);
		xret <= '0;
	endtask

	task automatic reset_state;
		logic [31:0] val, t1, t2;
		@(negedge clk);
		check("current_mode", current_mode, M);
		check("irq_en", irq_en, 0);
		check("timers", timers, 0);
		read_csr(CSR_MTVEC, val);
		check("mtvec", val, 0);
		read_csr(CSR_TIME, t1);
		read_csr(CSR_TIME, t2);
		check("time step", t2 - t1, 2); // two cycles per access
	endtask

	task automatic scratch_ops;
		logic [31:0] model [2];
		logic [31:0] d, old;
		csr_addr_t addr;
		model[0] = '0;
		model[1] = '0;
		for (int i = 0; i < 4; i++)
		begin
			for (int idx = 0; idx < 2; idx++)
			begin
				addr = idx ? CSR_SSCRATCH : CSR_MSCRATCH;
				d = $urandom;
				csr_rw(addr, d, old);
				check("scratch rw old", old, model[idx]);
				model[idx] = d;
				d = $urandom;
				csr_set(addr, d, old);
				check("scratch set old", old, model[idx]);
				model[idx] = model[idx] | d;
				d = $urandom;
				csr_clr(addr, d, old);
				check("scratch clr old", old, model[idx]);
				model[idx] = model[idx] & ~d;
				csr_set(addr, 32'h0, old);
				check("scratch clr result", old, model[idx]);
				read_csr(addr, old);
				check("scratch zero set", old, model[idx]);
			end
		end
	endtask

	task automatic machine_trap;
		logic [31:0] vec, pc, old, val, e;
		vec = $urandom;
		pc = $urandom;
		csr_rw(CSR_MTVEC, vec, old);
		csr_set(CSR_MSTATUS, 32'h8, old);
		do_trap({1'b0, I_ADDR_MISALIGNED}, pc, e);
		check("epc", e, {vec[31:2], 2'b00});
		read_csr(CSR_MEPC, val);
		check("mepc", val, {pc[31:2], 2'b00});
		read_csr(CSR_MCAUSE, val);
		check("mcause", val, 0);
		read_csr(CSR_MTVAL, val);
		check("mtval", val, pc);
		read_csr(CSR_MSTATUS, val);
		check("mstatus.mie", val[3], 0);
		check("mstatus.mpie", val[7], 1);
		check("mstatus.mpp", val[12:11], 2'b11);
		csr_clr(CSR_MSTATUS, 32'h1800, old); // mpp to U
		do_ret('{m_ret: 1'b1, s_ret: 1'b0, u_ret: 1'b0}, e);
		check("epc", e, {pc[31:2], 2'b00});
		@(negedge clk);
		check("current_mode", current_mode, U);
		read_csr(CSR_MSTATUS, val);
		check("mstatus.mie", val[3], 1);
	endtask

	task automatic delegation;
		logic [31:0] svec, uvec, mvec, pc, old, val, e;
		svec = $urandom;
		uvec = $urandom;
		mvec = $urandom;
		csr_rw(CSR_STVEC, svec, old);
		csr_rw(CSR_UTVEC, uvec, old);
		csr_rw(CSR_MTVEC, mvec, old);
		csr_rw(CSR_SEDELEG, 32'h0, old);

		pc = $urandom;
		do_trap({1'b0, ECALL_U}, pc, e);
		check("epc", e, {svec[31:2], 2'b00});
		@(negedge clk);
		check("current_mode", current_mode, S);
		read_csr(CSR_SEPC, val);
		check("sepc", val, {pc[31:2], 2'b00});
		read_csr(CSR_SCAUSE, val);
		check("scause", val, ECALL_U);
		read_csr(CSR_STVAL, val);
		check("stval", val, 0);
		do_ret('{m_ret: 1'b0, s_ret: 1'b1, u_ret: 1'b0}, e);
		check("epc", e, {pc[31:2], 2'b00});
		@(negedge clk);
		check("current_mode", current_mode, U);

		// delegated ecall stays in U
		csr_set(CSR_SEDELEG, 32'h1 << ECALL_U, old);
		pc = $urandom;
		do_trap({1'b0, ECALL_U}, pc, e);
		check("epc", e, {uvec[31:2], 2'b00});
		@(negedge clk);
		check("current_mode", current_mode, U);
		read_csr(CSR_UEPC, val);
		check("uepc", val, {pc[31:2], 2'b00});
		read_csr(CSR_UCAUSE, val);
		check("ucause", val, ECALL_U);

		csr_clr(CSR_SEDELEG, 32'h1 << ECALL_U, old);
		do_trap({1'b0, ECALL_U}, $urandom, e);
		@(negedge clk);
		check("current_mode", current_mode, S);
		pc = $urandom;
		do_trap({1'b0, ECALL_S}, pc, e); // medeleg still clear
		check("epc", e, {mvec[31:2], 2'b00});
		@(negedge clk);
		check("current_mode", current_mode, M);
		read_csr(CSR_MEPC, val);
		check("mepc", val, {pc[31:2], 2'b00});
		read_csr(CSR_MCAUSE, val);
		check("mcause", val, ECALL_S);
		read_csr(CSR_MSTATUS, val);
		check("mstatus.mpp", val[12:11], 2'b01);
	endtask

	task automatic timer_compare;
		logic [31:0] now, target, old;
		logic seen;
		read_csr(CSR_TIME, now);
		target = now + 20 + ($urandom % 41);
		csr_rw(CSR_MTIMECMP, target, old);
		@(posedge clk);
		park_req(CSR_TIME);
		seen = 1'b0;
		for (int cnt = 0; cnt < `TB_TIMEOUT_DEFAULT && !seen; cnt++)
		begin
			@(negedge clk);
			now = rd_data;
			// flag reflects the count before the last edge
			check("timers.m_timer", timers.m_timer, (now - 1) >= target);
			seen = timers.m_timer;
		end
		if (!seen)
			stop_on_timeout("timers.m_timer");
		repeat (5)
		begin
			@(negedge clk);
			check("timers.m_timer", timers.m_timer, 1);
		end
		check("timers.s_timer", timers.s_timer, 1); // stimecmp still 0
		check("timers.u_timer", timers.u_timer, 1);
	endtask

	task automatic irq_enables;
		logic [31:0] pc, old, val, e;
		csr_rw(CSR_MIE, 32'h880, old);
		csr_clr(CSR_MSTATUS, 32'h8, old);
		@(negedge clk);
		check("irq_en.m_eie", irq_en.m_eie, 0);
		check("irq_en.m_tie", irq_en.m_tie, 0);
		csr_set(CSR_MSTATUS, 32'h8, old);
		@(negedge clk);
		check("irq_en.m_eie", irq_en.m_eie, 1);
		check("irq_en.m_tie", irq_en.m_tie, 1);

		// mie write in the trap cycle must be dropped
		pc = $urandom;
		@(posedge clk);
		csr_req <= '{valid: 1'b1, op: CSR_RW, addr: CSR_MIE, src: 32'h0};
		trap <= '{pending: 1'b1, cause: {1'b0, BREAKPOINT}, pc: pc};
		@(negedge clk);
		@(posedge clk);
		park_req(CSR_MIE);
		trap <= '{pending: 1'b0, cause: '0, pc: '0};
		@(negedge clk);
		check("current_mode", current_mode, M);
		check("irq_en.m_eie", irq_en.m_eie, 0);
		read_csr(CSR_MIE, val);
		check("mie", val, 32'h880);
		do_ret('{m_ret: 1'b1, s_ret: 1'b0, u_ret: 1'b0}, e);
		check("epc", e, {pc[31:2], 2'b00});
		@(negedge clk);
		check("irq_en.m_eie", irq_en.m_eie, 1);
		check("irq_en.m_tie", irq_en.m_tie, 1);
	endtask

	initial
	begin
		nrst = 1'b0;
		csr_req = '{valid: 1'b0, op: CSR_RS, addr: CSR_MSTATUS, src: '0};
		trap = '{pending: 1'b0, cause: '0, pc: '0};
		xret = '0;
		m_interrupt = 1'b0;
		s_interrupt = 1'b0;
		u_interrupt = 1'b0;
		void'($urandom(32'hfa0b));
		repeat (3) @(posedge clk);
		nrst <= 1'b1;

		reset_state();
		scratch_ops();
		machine_trap();
		delegation();
		timer_compare();
		irq_enables();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/csr_pkg.sv
design/csr_unit.sv
design/csr_timer.sv
design/csr_regfile.sv
design/csr_top.sv
bench/csr_tb.sv

//--- Makefile
# Verilator flow for the CSR subsystem

VERILATOR ?= verilator
TOP       ?= csr_tb
SEED      ?= 1
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := RESULT: PASS

LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard design/*.sv design/*.svh bench/*.sv)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
